//--- design/cachePkg.sv
package cachePkg;

    // ******************************
    // Cache geometry
    // ******************************

    // The low idxWidth bits of a line address select the set.
    localparam int addrWidth = 32;
    localparam int idxWidth = 6;
    localparam int tagWidth = addrWidth - idxWidth;

    localparam int numWays = 4;
    localparam int wayWidth = $clog2(numWays);

    // ******************************
    // Queues and memory model
    // ******************************

    // Cycles a miss spends at the head of the miss queue before its fill.
    localparam int memLatency = 8;

    localparam int pfQueueDepth = 4;
    localparam int missQueueDepth = 2;

    // ******************************
    // Miss record
    // ******************************

    // A regular miss evicts a valid line and a no-evict miss fills an empty way.
    typedef enum logic {
        regularMiss = 1'b0,
        noEvictMiss = 1'b1
    } missType;

    typedef struct packed {
        logic [addrWidth-1:0] lineAddr;
        logic [wayWidth-1:0] victimWay;
        logic [tagWidth-1:0] oldTag;
        missType missKind;
    } missRecord;

endpackage

//--- design/syncFifo.sv
`timescale 1ns/1ns

module syncFifo #(
    parameter int depth = 4,
    parameter type dataType = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  dataType pushData,
    input  logic    pop,
    output dataType popData,
    output logic    notEmpty,
    output logic    notFull
);

    dataType mem [depth];

    logic [$clog2(depth)-1:0] rdPtr;
    logic [$clog2(depth)-1:0] wrPtr;
    logic [$clog2(depth+1)-1:0] count;
    logic doPush;
    logic doPop;

    // Requests against a full or empty queue are ignored.
    assign doPush = push && notFull;
    assign doPop = pop && notEmpty;

    assign notEmpty = count != 0;
    assign notFull = count != depth;
    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == depth - 1) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == depth - 1) ? '0 : rdPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

endmodule

//--- design/strideDetector.sv
`timescale 1ns/1ns

module strideDetector (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           loadValid,
    input  logic [cachePkg::addrWidth-1:0] loadAddr,
    output logic                           pfValid,
    output logic [cachePkg::addrWidth-1:0] pfAddr
);

    logic [cachePkg::addrWidth-1:0] lastAddr;
    logic [cachePkg::addrWidth-1:0] lastStride;
    logic [cachePkg::addrWidth-1:0] stride;
    logic haveAddr;
    logic haveStride;
    logic confirmed;

    // Wrapping difference, so negative strides work as well.
    assign stride = loadAddr - lastAddr;

    // The stride counts only if the previous one came from two real loads.
    assign confirmed = haveStride && (stride == lastStride) && (stride != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            haveAddr <= 1'b0;
            haveStride <= 1'b0;
            pfValid <= 1'b0;
        end else begin
            pfValid <= loadValid && confirmed;
            if (loadValid) begin
                haveAddr <= 1'b1;
                haveStride <= haveAddr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (loadValid) begin
            lastAddr <= loadAddr;
            lastStride <= stride;
            pfAddr <= loadAddr + stride;
        end
    end

endmodule

//--- design/tagTable.sv
`timescale 1ns/1ns

module tagTable (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               readValid,
    input  logic [cachePkg::idxWidth-1:0]                      readIdx,
    output logic                                               readReady,
    output logic [cachePkg::numWays-1:0][cachePkg::tagWidth-1:0] resultTags,
    output logic [cachePkg::numWays-1:0]                       resultValids,
    input  logic                                               wrValid,
    input  logic [cachePkg::idxWidth-1:0]                      wrIdx,
    input  logic [cachePkg::wayWidth-1:0]                      wrWay,
    input  logic [cachePkg::tagWidth-1:0]                      wrTag
);

    logic [cachePkg::tagWidth-1:0] tags [2**cachePkg::idxWidth][cachePkg::numWays];
    logic [cachePkg::numWays-1:0] valids [2**cachePkg::idxWidth];
    logic [cachePkg::idxWidth-1:0] readIdxQ;

    // The table has a single port, so a fill write blocks new reads.
    assign readReady = !wrValid;

    // ******************************
    // Storage and fill write
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < 2**cachePkg::idxWidth; s++) begin
                valids[s] <= '0;
                for (int w = 0; w < cachePkg::numWays; w++) begin
                    tags[s][w] <= '0;
                end
            end
        end else if (wrValid) begin
            tags[wrIdx][wrWay] <= wrTag;
            valids[wrIdx][wrWay] <= 1'b1;
        end
    end

    // ******************************
    // Two-cycle read
    // ******************************

    // First edge captures the index, second edge captures the set contents.
    always_ff @(posedge clk) begin
        if (readValid) begin
            readIdxQ <= readIdx;
        end
        resultValids <= valids[readIdxQ];
        for (int w = 0; w < cachePkg::numWays; w++) begin
            resultTags[w] <= tags[readIdxQ][w];
        end
    end

endmodule

//--- design/prefetchExecutor.sv
`timescale 1ns/1ns

module prefetchExecutor (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               reqValid,
    input  logic [cachePkg::addrWidth-1:0]                     reqAddr,
    output logic                                               reqReady,
    output logic                                               readValid,
    output logic [cachePkg::idxWidth-1:0]                      readIdx,
    input  logic                                               readReady,
    input  logic [cachePkg::numWays-1:0][cachePkg::tagWidth-1:0] resultTags,
    input  logic [cachePkg::numWays-1:0]                       resultValids,
    output logic                                               missValid,
    output cachePkg::missRecord                                missData,
    input  logic                                               missReady,
    output logic                                               ackValid,
    output logic [cachePkg::addrWidth-1:0]                     ackAddr,
    output logic                                               ackExisting,
    output logic                                               dropValid,
    output logic [cachePkg::addrWidth-1:0]                     dropAddr
);

    logic s0Valid;
    logic s1Valid;
    logic [cachePkg::addrWidth-1:0] s0Addr;
    logic [cachePkg::addrWidth-1:0] s1Addr;
    logic [cachePkg::numWays-1:0] hitVec;
    logic hit;
    logic [cachePkg::wayWidth-1:0] victimCnt;

    // A request is taken whenever the table can start a read.
    assign reqReady = readReady;
    assign readValid = reqValid && readReady;
    assign readIdx = reqAddr[cachePkg::idxWidth-1:0];

    // ******************************
    // Tag compare in stage 1
    // ******************************

    always_comb begin
        for (int w = 0; w < cachePkg::numWays; w++) begin
            hitVec[w] = resultValids[w]
                && (resultTags[w] == s1Addr[cachePkg::addrWidth-1:cachePkg::idxWidth]);
        end
    end

    // A line is never filled into two ways, so at most one bit is set.
    assign hit = |hitVec;

    assign missValid = s1Valid && !hit;

    always_comb begin
        missData.lineAddr = s1Addr;
        missData.victimWay = victimCnt;
        missData.oldTag = resultTags[victimCnt];
        missData.missKind = resultValids[victimCnt] ? cachePkg::regularMiss
                                                    : cachePkg::noEvictMiss;
    end

    // ******************************
    // Pipeline and result pulses
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
            ackValid <= 1'b0;
            dropValid <= 1'b0;
            victimCnt <= '0;
        end else begin
            s0Valid <= readValid;
            s1Valid <= s0Valid;
            ackValid <= s1Valid && (hit || missReady);
            dropValid <= s1Valid && !hit && !missReady;
            // Only a miss the handler accepts moves the victim pointer.
            if (missValid && missReady) begin
                victimCnt <= victimCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (readValid) begin
            s0Addr <= reqAddr;
        end
        s1Addr <= s0Addr;
        ackAddr <= s1Addr;
        ackExisting <= hit;
        dropAddr <= s1Addr;
    end

endmodule

//--- design/missHandler.sv
`timescale 1ns/1ns

module missHandler (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           missValid,
    input  cachePkg::missRecord            missData,
    output logic                           missReady,
    output logic                           wrValid,
    output logic [cachePkg::idxWidth-1:0]  wrIdx,
    output logic [cachePkg::wayWidth-1:0]  wrWay,
    output logic [cachePkg::tagWidth-1:0]  wrTag,
    output logic                           fillValid,
    output logic [cachePkg::addrWidth-1:0] fillAddr,
    output logic [cachePkg::wayWidth-1:0]  fillWay,
    output logic                           fillEvict
);

    cachePkg::missRecord head;
    logic headValid;
    logic notFull;
    logic expire;
    logic [$clog2(cachePkg::memLatency)-1:0] latCnt;

    assign missReady = notFull;

    syncFifo #(
        .depth   (cachePkg::missQueueDepth),
        .dataType(cachePkg::missRecord)
    ) missQueue (
        .clk     (clk),
        .rst     (rst),
        .push    (missValid),
        .pushData(missData),
        .pop     (expire),
        .popData (head),
        .notEmpty(headValid),
        .notFull (notFull)
    );

    // ******************************
    // Memory latency model
    // ******************************

    // The counter starts at zero in the first cycle an entry sits at the head.
    assign expire = headValid && (latCnt == cachePkg::memLatency - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            latCnt <= '0;
        end else if (expire) begin
            latCnt <= '0;
        end else if (headValid) begin
            latCnt <= latCnt + 1'b1;
        end
    end

    // Table write and fill report go out together.
    assign wrValid = expire;
    assign wrIdx = head.lineAddr[cachePkg::idxWidth-1:0];
    assign wrWay = head.victimWay;
    assign wrTag = head.lineAddr[cachePkg::addrWidth-1:cachePkg::idxWidth];

    assign fillValid = expire;
    assign fillAddr = head.lineAddr;
    assign fillWay = head.victimWay;
    assign fillEvict = head.missKind == cachePkg::regularMiss;

endmodule

//--- design/prefetchSubsystem.sv
`timescale 1ns/1ns

module prefetchSubsystem (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           loadValid,
    input  logic [cachePkg::addrWidth-1:0] loadAddr,
    output logic                           ackValid,
    output logic [cachePkg::addrWidth-1:0] ackAddr,
    output logic                           ackExisting,
    output logic                           dropValid,
    output logic [cachePkg::addrWidth-1:0] dropAddr,
    output logic                           fillValid,
    output logic [cachePkg::addrWidth-1:0] fillAddr,
    output logic [cachePkg::wayWidth-1:0]  fillWay,
    output logic                           fillEvict
);

    logic pfValid;
    logic [cachePkg::addrWidth-1:0] pfAddr;
    logic pfQueueNotFull;

    logic reqValid;
    logic [cachePkg::addrWidth-1:0] reqAddr;
    logic reqReady;

    logic readValid;
    logic [cachePkg::idxWidth-1:0] readIdx;
    logic readReady;
    logic [cachePkg::numWays-1:0][cachePkg::tagWidth-1:0] resultTags;
    logic [cachePkg::numWays-1:0] resultValids;

    logic missValid;
    cachePkg::missRecord missData;
    logic missReady;

    logic wrValid;
    logic [cachePkg::idxWidth-1:0] wrIdx;
    logic [cachePkg::wayWidth-1:0] wrWay;
    logic [cachePkg::tagWidth-1:0] wrTag;

    strideDetector detector (
        .clk      (clk),
        .rst      (rst),
        .loadValid(loadValid),
        .loadAddr (loadAddr),
        .pfValid  (pfValid),
        .pfAddr   (pfAddr)
    );

    // The detector cannot stall and relies on the queue depth for the load rate.
    syncFifo #(
        .depth   (cachePkg::pfQueueDepth),
        .dataType(logic [cachePkg::addrWidth-1:0])
    ) pfQueue (
        .clk     (clk),
        .rst     (rst),
        .push    (pfValid),
        .pushData(pfAddr),
        .pop     (reqReady),
        .popData (reqAddr),
        .notEmpty(reqValid),
        .notFull (pfQueueNotFull)
    );

    prefetchExecutor executor (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (reqValid),
        .reqAddr     (reqAddr),
        .reqReady    (reqReady),
        .readValid   (readValid),
        .readIdx     (readIdx),
        .readReady   (readReady),
        .resultTags  (resultTags),
        .resultValids(resultValids),
        .missValid   (missValid),
        .missData    (missData),
        .missReady   (missReady),
        .ackValid    (ackValid),
        .ackAddr     (ackAddr),
        .ackExisting (ackExisting),
        .dropValid   (dropValid),
        .dropAddr    (dropAddr)
    );

    tagTable table0 (
        .clk         (clk),
        .rst         (rst),
        .readValid   (readValid),
        .readIdx     (readIdx),
        .readReady   (readReady),
        .resultTags  (resultTags),
        .resultValids(resultValids),
        .wrValid     (wrValid),
        .wrIdx       (wrIdx),
        .wrWay       (wrWay),
        .wrTag       (wrTag)
    );

    missHandler handler (
        .clk      (clk),
        .rst      (rst),
        .missValid(missValid),
        .missData (missData),
        .missReady(missReady),
        .wrValid  (wrValid),
        .wrIdx    (wrIdx),
        .wrWay    (wrWay),
        .wrTag    (wrTag),
        .fillValid(fillValid),
        .fillAddr (fillAddr),
        .fillWay  (fillWay),
        .fillEvict(fillEvict)
    );

endmodule

//--- verification/prefetchSubsystem_sva.sv
`timescale 1ns/1ns

module prefetchSubsystemSva (
    input logic                          clk,
    input logic                          rst,
    input logic                          pfValid,
    input logic                          pfQueueNotFull,
    input logic                          readValid,
    input logic                          wrValid,
    input logic                          ackValid,
    input logic                          dropValid,
    input logic                          fillValid,
    input logic [cachePkg::wayWidth-1:0] fillWay
);

    // Accepted misses take ways in counter order and the miss queue keeps that order.
    logic [cachePkg::wayWidth-1:0] fillCount;

    always_ff @(posedge clk) begin
        if (rst) begin
            fillCount <= '0;
        end else if (fillValid) begin
            fillCount <= fillCount + 1'b1;
        end
    end

    noFullPush: assert property (@(posedge clk) disable iff (rst) pfValid |-> pfQueueNotFull)
        else $error("prefetch pushed into a full queue");

    writeBeforeRead: assert property (@(posedge clk) disable iff (rst) wrValid |-> !readValid)
        else $error("table read issued during a fill write");

    ackOrDrop: assert property (@(posedge clk) disable iff (rst) !(ackValid && dropValid))
        else $error("ack and drop pulsed together");

    fillWayOrder: assert property (@(posedge clk) disable iff (rst)
        fillValid |-> fillWay == fillCount)
        else $error("fill way differs from the round-robin victim");

endmodule

bind prefetchSubsystem prefetchSubsystemSva rules (
    .clk           (clk),
    .rst           (rst),
    .pfValid       (pfValid),
    .pfQueueNotFull(pfQueueNotFull),
    .readValid     (readValid),
    .wrValid       (wrValid),
    .ackValid      (ackValid),
    .dropValid     (dropValid),
    .fillValid     (fillValid),
    .fillWay       (fillWay)
);

//--- verification/tbPrefetchSubsystem.sv
`timescale 1ns/1ns

module tbPrefetchSubsystem;

    logic clk = 1'b0;
    logic rst;
    logic loadValid;
    logic [cachePkg::addrWidth-1:0] loadAddr;
    logic ackValid;
    logic [cachePkg::addrWidth-1:0] ackAddr;
    logic ackExisting;
    logic dropValid;
    logic [cachePkg::addrWidth-1:0] dropAddr;
    logic fillValid;
    logic [cachePkg::addrWidth-1:0] fillAddr;
    logic [cachePkg::wayWidth-1:0] fillWay;
    logic fillEvict;

    int seed = 32'h79b3ef6a;
    int cycleCount = 0;
    int cycleLimit;
    int loadGap;
    int dropCount = 0;
    int hitCount = 0;
    int evictCount = 0;

    // Detector model, shadow table and queues of expected results.
    logic [cachePkg::addrWidth-1:0] lastAddr = '0;
    logic [cachePkg::addrWidth-1:0] lastStride = '0;
    logic haveAddr = 1'b0;
    logic haveStride = 1'b0;
    logic [cachePkg::wayWidth-1:0] victim = '0;
    logic [cachePkg::tagWidth-1:0] shadowTag [2**cachePkg::idxWidth][cachePkg::numWays];
    logic shadowValid [2**cachePkg::idxWidth][cachePkg::numWays];
    logic [cachePkg::addrWidth-1:0] expectAddr [$];
    int expectDue [$];
    logic [cachePkg::addrWidth-1:0] fillAddrQ [$];
    logic [cachePkg::wayWidth-1:0] fillWayQ [$];
    logic fillEvictQ [$];
    logic [cachePkg::addrWidth-1:0] pendAddr [$];
    logic [cachePkg::wayWidth-1:0] pendWay [$];
    int pendStamp [$];
    logic [cachePkg::addrWidth-1:0] base;
    logic [cachePkg::addrWidth-1:0] stride;

    prefetchSubsystem uut (
        .clk        (clk),
        .rst        (rst),
        .loadValid  (loadValid),
        .loadAddr   (loadAddr),
        .ackValid   (ackValid),
        .ackAddr    (ackAddr),
        .ackExisting(ackExisting),
        .dropValid  (dropValid),
        .dropAddr   (dropAddr),
        .fillValid  (fillValid),
        .fillAddr   (fillAddr),
        .fillWay    (fillWay),
        .fillEvict  (fillEvict)
    );

    always #10 clk = ~clk;

    task automatic reportFailure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
            input logic [31:0] expected);
        assert (got === expected)
        else reportFailure($sformatf("[FAIL] %0t ns %s got %h expected %h",
            $time, name, got, expected));
    endtask

    // ******************************
    // Reference functions
    // ******************************

    // A stride is confirmed when it repeats the previous non-zero stride.
    function automatic logic strideConfirmed(input logic [cachePkg::addrWidth-1:0] newStride,
            input logic [cachePkg::addrWidth-1:0] prevStride, input logic prevDefined);
        return prevDefined && (newStride == prevStride) && (newStride != '0);
    endfunction

    function automatic logic lineStored(input logic [cachePkg::addrWidth-1:0] addr);
        logic found;
        found = 1'b0;
        for (int w = 0; w < cachePkg::numWays; w++) begin
            if (shadowValid[addr[cachePkg::idxWidth-1:0]][w]
                    && shadowTag[addr[cachePkg::idxWidth-1:0]][w]
                    == addr[cachePkg::addrWidth-1:cachePkg::idxWidth]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // A fill reaches the table one edge after its pulse, and a read samples the set
    // two edges before the ack, so fills count only three cycles later.
    task automatic applyFills();
        logic [cachePkg::addrWidth-1:0] addr;
        logic [cachePkg::wayWidth-1:0] way;
        while (pendStamp.size() != 0 && pendStamp[0] <= cycleCount - 3) begin
            addr = pendAddr.pop_front();
            way = pendWay.pop_front();
            void'(pendStamp.pop_front());
            shadowTag[addr[cachePkg::idxWidth-1:0]][way] =
                addr[cachePkg::addrWidth-1:cachePkg::idxWidth];
            shadowValid[addr[cachePkg::idxWidth-1:0]][way] = 1'b1;
        end
    endtask

    task automatic checkResult();
        logic [cachePkg::addrWidth-1:0] addr;
        logic present;
        int due;
        assert (expectAddr.size() != 0)
        else reportFailure("An ack or drop pulse arrived with no prefetch outstanding.");
        addr = expectAddr.pop_front();
        due = expectDue.pop_front();
        present = lineStored(addr);
        if (ackValid) begin
            checkValue("ackAddr", ackAddr, addr);
            checkValue("ackExisting", ackExisting, present);
            if (due != 0) begin
                checkValue("ack cycle", cycleCount, due);
            end
            if (present) begin
                hitCount++;
            end else begin
                fillAddrQ.push_back(addr);
                fillWayQ.push_back(victim);
                fillEvictQ.push_back(shadowValid[addr[cachePkg::idxWidth-1:0]][victim]);
                victim++;
            end
        end else begin
            checkValue("dropAddr", dropAddr, addr);
            assert (!present) else reportFailure("A prefetch that hits the table was dropped.");
            dropCount++;
        end
    endtask

    task automatic checkFill();
        assert (fillAddrQ.size() != 0)
        else reportFailure("A fill pulse arrived with no accepted miss outstanding.");
        checkValue("fillAddr", fillAddr, fillAddrQ.pop_front());
        checkValue("fillWay", fillWay, fillWayQ.pop_front());
        checkValue("fillEvict", fillEvict, fillEvictQ.pop_front());
        if (fillEvict) begin
            evictCount++;
        end
        pendAddr.push_back(fillAddr);
        pendWay.push_back(fillWay);
        pendStamp.push_back(cycleCount);
    endtask

    // Outputs are compared at the falling edge, away from the register updates.
    always @(negedge clk) begin
        if (!rst) begin
            applyFills();
            if (ackValid || dropValid) begin
                checkResult();
            end
            if (fillValid) begin
                checkFill();
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            reportFailure("The run passed its cycle limit before all scenarios finished.");
        end
    end

    // ******************************
    // Stimulus
    // ******************************

    task automatic loadLine(input logic [cachePkg::addrWidth-1:0] addr, input logic timed);
        logic [cachePkg::addrWidth-1:0] newStride;
        @(posedge clk);
        newStride = addr - lastAddr;
        if (strideConfirmed(newStride, lastStride, haveStride)) begin
            expectAddr.push_back(addr + newStride);
            // Detector, queue head, read, stage 1 and ack each take one edge.
            expectDue.push_back(timed ? cycleCount + 6 : 0);
        end
        haveStride = haveAddr;
        haveAddr = 1'b1;
        lastAddr = addr;
        lastStride = newStride;
        loadValid <= 1'b1;
        loadAddr <= addr;
    endtask

    task automatic spacedLoads(input logic [cachePkg::addrWidth-1:0] first,
            input logic [cachePkg::addrWidth-1:0] step, input int count);
        for (int i = 0; i < count; i++) begin
            loadLine(first + i * step, 1'b1);
            @(posedge clk);
            loadValid <= 1'b0;
            repeat (loadGap - 2) @(posedge clk);
        end
    endtask

    task automatic burstLoads(input logic [cachePkg::addrWidth-1:0] first,
            input logic [cachePkg::addrWidth-1:0] step, input int count);
        for (int i = 0; i < count; i++) begin
            loadLine(first + i * step, 1'b0);
        end
        @(posedge clk);
        loadValid <= 1'b0;
    endtask

    task automatic drain();
        while (expectAddr.size() != 0 || fillAddrQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (cachePkg::memLatency + 4) @(posedge clk);
    endtask

    initial begin
        loadGap = cachePkg::memLatency + 4;
        // Reset, twenty spaced loads, one burst, at most sixteen misses.
        cycleLimit = 5 * (16 + 20 * loadGap + 8) + cachePkg::memLatency * 16;
        rst = 1'b1;
        loadValid = 1'b0;
        loadAddr = '0;
        for (int s = 0; s < 2**cachePkg::idxWidth; s++) begin
            for (int w = 0; w < cachePkg::numWays; w++) begin
                shadowValid[s][w] = 1'b0;
            end
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!ackValid && !dropValid && !fillValid)
        else reportFailure("A result pulse was high right after reset.");

        // New lines first, then the same sequence again once they are filled.
        base = $random(seed) & 32'h00ff_ffff;
        stride = ($random(seed) & 32'h3ff) + 1;
        spacedLoads(base, stride, 6);
        drain();
        spacedLoads(base, stride, 6);
        drain();

        // Back-to-back misses overrun the miss queue.
        base = $random(seed);
        stride = ($random(seed) & 32'hfff) + 1;
        burstLoads(base, stride, 8);
        drain();

        // A stride of one set size keeps every prefetch in a single set.
        base = $random(seed);
        spacedLoads(base, 2**cachePkg::idxWidth, 8);
        drain();

        if (expectAddr.size() == 0 && fillAddrQ.size() == 0 && dropCount > 0
                && hitCount >= 4 && evictCount > 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            reportFailure("A scenario ended without its expected hits, drops or evictions.");
        end
    end

endmodule

//--- all.f
design/cachePkg.sv
design/syncFifo.sv
design/strideDetector.sv
design/tagTable.sv
design/prefetchExecutor.sv
design/missHandler.sv
design/prefetchSubsystem.sv
verification/prefetchSubsystem_sva.sv
verification/tbPrefetchSubsystem.sv

//--- Bender.yml
package:
  name: prefetch_subsystem

sources:
  - design/cachePkg.sv
  - design/syncFifo.sv
  - design/strideDetector.sv
  - design/tagTable.sv
  - design/prefetchExecutor.sv
  - design/missHandler.sv
  - design/prefetchSubsystem.sv
  - target: simulation
    files:
      - verification/prefetchSubsystem_sva.sv
      - verification/tbPrefetchSubsystem.sv
